//--- rtl/wb_pkg.sv
package wb_pkg;

        // Widths with a meaning of their own.
        localparam int PHY_REGS = 46;

        typedef logic [31:0]                   word_t;
        typedef logic [$clog2(PHY_REGS)-1:0]   reg_idx_t;
        typedef logic [4:0]                    mode_t;

        // Physical register map.
        localparam reg_idx_t ARCH_PC          = reg_idx_t'(15);
        localparam reg_idx_t PHY_RAZ_REGISTER = reg_idx_t'(16);
        localparam reg_idx_t PHY_CPSR         = reg_idx_t'(17);
        localparam reg_idx_t PHY_FIQ_R14      = reg_idx_t'(24);
        localparam reg_idx_t PHY_IRQ_R14      = reg_idx_t'(26);
        localparam reg_idx_t PHY_SVC_R14      = reg_idx_t'(28);
        localparam reg_idx_t PHY_UND_R14      = reg_idx_t'(30);
        localparam reg_idx_t PHY_ABT_R14      = reg_idx_t'(32);
        localparam reg_idx_t PHY_FIQ_SPSR     = reg_idx_t'(33);
        localparam reg_idx_t PHY_IRQ_SPSR     = reg_idx_t'(34);
        localparam reg_idx_t PHY_SVC_SPSR     = reg_idx_t'(35);
        localparam reg_idx_t PHY_UND_SPSR     = reg_idx_t'(36);
        localparam reg_idx_t PHY_ABT_SPSR     = reg_idx_t'(37);

        // ARM mode encodings.
        localparam mode_t MODE_USR = 5'h10;
        localparam mode_t MODE_FIQ = 5'h11;
        localparam mode_t MODE_IRQ = 5'h12;
        localparam mode_t MODE_SVC = 5'h13;
        localparam mode_t MODE_ABT = 5'h17;
        localparam mode_t MODE_UND = 5'h1B;

        // Status word bits; mode sits in [4:0].
        localparam int CPSR_I = 7;
        localparam int CPSR_F = 6;
        localparam int CPSR_T = 5;

        // Exception vectors.
        localparam word_t UND_VECTOR  = 32'h0000_0004;
        localparam word_t SWI_VECTOR  = 32'h0000_0008;
        localparam word_t PABT_VECTOR = 32'h0000_000C;
        localparam word_t DABT_VECTOR = 32'h0000_0010;
        localparam word_t IRQ_VECTOR  = 32'h0000_0018;
        localparam word_t FIQ_VECTOR  = 32'h0000_001C;

        localparam word_t PC_STEP = 32'd4;

        typedef enum logic [2:0] {
                WB_HOLD,
                WB_ADVANCE,
                WB_REDIRECT,
                WB_EXCEPTION,
                WB_COMMIT
        } wb_kind_e;

        typedef struct packed {
                wb_kind_e kind;
                word_t    target;
                mode_t    exc_mode;
                reg_idx_t lr_idx;
                reg_idx_t spsr_idx;
                logic     mask_fiq;
                logic     fiq_ack;
                logic     irq_ack;
        } wb_event_t;

        typedef struct packed {
                logic     wen;
                reg_idx_t wa1;
                reg_idx_t wa2;
                word_t    wdata1;
                word_t    wdata2;
        } wb_write_t;

        typedef struct packed {
                logic     valid;
                logic     mem_load;
                reg_idx_t wr_index;
                reg_idx_t wr_index_1;
                word_t    wr_data;
                word_t    wr_data_1;
                word_t    flags;
        } commit_t;

endpackage

//--- rtl/wb_event_decode.sv
`timescale 1ns/1ps

module wb_event_decode
(
        // Bit 5 is dabt, then fiq, irq, pabt, swi; bit 0 is und.
        input  logic [5:0]          i_exc,
        input  logic                i_data_stall,
        input  logic                i_clear_from_alu,
        input  wb_pkg::word_t       i_pc_from_alu,
        input  logic                i_stall_from_issue,
        input  logic                i_clear_from_decode,
        input  wb_pkg::word_t       i_pc_from_decode,
        input  logic                i_stall_from_decode,
        input  logic                i_code_stall,
        input  wb_pkg::commit_t     i_commit,
        output wb_pkg::wb_event_t   o_event
);

        import wb_pkg::*;

        // Sets up an exception entry in one go.
        function automatic wb_event_t exc_entry(input word_t vector, input mode_t mode,
                                                input reg_idx_t lr, input reg_idx_t spsr);
                wb_event_t ev;

                ev          = '0;
                ev.kind     = WB_EXCEPTION;
                ev.target   = vector;
                ev.exc_mode = mode;
                ev.lr_idx   = lr;
                ev.spsr_idx = spsr;
                return ev;
        endfunction

        always_comb
        begin
                o_event          = '0;
                o_event.kind     = WB_ADVANCE;
                o_event.exc_mode = MODE_USR;
                o_event.lr_idx   = PHY_RAZ_REGISTER;
                o_event.spsr_idx = PHY_RAZ_REGISTER;

                // Exceptions first, highest line wins.
                if (i_exc[5])
                        o_event = exc_entry(DABT_VECTOR, MODE_ABT, PHY_ABT_R14, PHY_ABT_SPSR);
                else if (i_exc[4])
                begin
                        o_event = exc_entry(FIQ_VECTOR, MODE_FIQ, PHY_FIQ_R14, PHY_FIQ_SPSR);
                        o_event.mask_fiq = 1'b1;
                        o_event.fiq_ack  = 1'b1;
                end
                else if (i_exc[3])
                begin
                        o_event = exc_entry(IRQ_VECTOR, MODE_IRQ, PHY_IRQ_R14, PHY_IRQ_SPSR);
                        o_event.irq_ack = 1'b1;
                end
                else if (i_exc[2])
                        o_event = exc_entry(PABT_VECTOR, MODE_ABT, PHY_ABT_R14, PHY_ABT_SPSR);
                else if (i_exc[1])
                        o_event = exc_entry(SWI_VECTOR, MODE_SVC, PHY_SVC_R14, PHY_SVC_SPSR);
                else if (i_exc[0])
                        o_event = exc_entry(UND_VECTOR, MODE_UND, PHY_UND_R14, PHY_UND_SPSR);
                else if (i_commit.valid)
                        o_event.kind = WB_COMMIT;
                // PC chain, stalls and clears in pipeline order.
                else if (i_data_stall)
                        o_event.kind = WB_HOLD;
                else if (i_clear_from_alu)
                begin
                        o_event.kind   = WB_REDIRECT;
                        o_event.target = i_pc_from_alu;
                end
                else if (i_stall_from_issue)
                        o_event.kind = WB_HOLD;
                else if (i_clear_from_decode)
                begin
                        o_event.kind   = WB_REDIRECT;
                        o_event.target = i_pc_from_decode;
                end
                else if (i_stall_from_decode || i_code_stall)
                        o_event.kind = WB_HOLD;
        end

endmodule

//--- rtl/wb_state_execute.sv
`timescale 1ns/1ps

module wb_state_execute
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  wb_pkg::wb_event_t   i_event,
        input  wb_pkg::commit_t     i_commit,
        // Return address captured at fetch.
        input  wb_pkg::word_t       i_pc_buf,
        output wb_pkg::word_t       o_pc,
        output wb_pkg::word_t       o_cpsr,
        output wb_pkg::wb_write_t   o_write,
        output logic                o_clear_from_writeback,
        output logic                o_fiq_ack,
        output logic                o_irq_ack
);

        import wb_pkg::*;

        word_t pc_ff;
        word_t pc_nxt;
        word_t cpsr_ff;
        word_t cpsr_nxt;

        logic  pc_hit_0;
        logic  pc_hit_1;

        // Commit lanes that land on the PC.
        assign pc_hit_0 = (i_commit.wr_index == ARCH_PC);
        assign pc_hit_1 = i_commit.mem_load && (i_commit.wr_index_1 == ARCH_PC);

        always_comb
        begin
                pc_nxt                 = pc_ff;
                cpsr_nxt               = cpsr_ff;
                o_write.wen            = 1'b0;
                o_write.wa1            = PHY_RAZ_REGISTER;
                o_write.wa2            = PHY_RAZ_REGISTER;
                o_write.wdata1         = '0;
                o_write.wdata2         = '0;
                o_clear_from_writeback = 1'b0;

                case (i_event.kind)
                        WB_ADVANCE:
                        begin
                                pc_nxt = pc_ff + PC_STEP;
                        end
                        WB_REDIRECT:
                        begin
                                pc_nxt = i_event.target;
                        end
                        WB_EXCEPTION:
                        begin
                                // Save LR and SPSR together, then vector.
                                pc_nxt                 = i_event.target;
                                o_write.wen            = 1'b1;
                                o_write.wa1            = i_event.lr_idx;
                                o_write.wdata1         = i_pc_buf;
                                o_write.wa2            = i_event.spsr_idx;
                                o_write.wdata2         = cpsr_ff;
                                cpsr_nxt[4:0]          = i_event.exc_mode;
                                cpsr_nxt[CPSR_I]       = 1'b1;
                                if (i_event.mask_fiq)
                                        cpsr_nxt[CPSR_F] = 1'b1;
                                o_clear_from_writeback = 1'b1;
                        end
                        WB_COMMIT:
                        begin
                                o_write.wen    = 1'b1;
                                o_write.wa1    = i_commit.wr_index;
                                o_write.wdata1 = i_commit.wr_data;
                                o_write.wa2    = i_commit.mem_load ? i_commit.wr_index_1
                                                                   : PHY_RAZ_REGISTER;
                                o_write.wdata2 = i_commit.mem_load ? i_commit.wr_data_1 : '0;

                                // Status source, first match wins.
                                if (pc_hit_0)
                                        cpsr_nxt = i_commit.wr_data_1;
                                else if (i_commit.wr_index == PHY_CPSR)
                                        cpsr_nxt = i_commit.wr_data;
                                else if (i_commit.mem_load && i_commit.wr_index_1 == PHY_CPSR)
                                        cpsr_nxt = i_commit.wr_data_1;
                                else
                                        cpsr_nxt = i_commit.flags;

                                if (pc_hit_0)
                                        pc_nxt = i_commit.wr_data;
                                else if (pc_hit_1)
                                        pc_nxt = i_commit.wr_data_1;

                                o_clear_from_writeback = pc_hit_0 || pc_hit_1;
                        end
                        default:
                        begin
                                // Hold, PC stays put.
                                pc_nxt = pc_ff;
                        end
                endcase
        end

        assign o_fiq_ack = i_event.fiq_ack;
        assign o_irq_ack = i_event.irq_ack;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        // Start at zero in SVC with both interrupts masked.
                        pc_ff            <= '0;
                        cpsr_ff          <= '0;
                        cpsr_ff[4:0]     <= MODE_SVC;
                        cpsr_ff[CPSR_I]  <= 1'b1;
                        cpsr_ff[CPSR_F]  <= 1'b1;
                end
                else
                begin
                        pc_ff            <= {pc_nxt[31:1], 1'b0};
                        cpsr_ff          <= cpsr_nxt;
                        // ARM state only.
                        cpsr_ff[CPSR_T]  <= 1'b0;
                end
        end

        assign o_pc   = pc_ff;
        assign o_cpsr = cpsr_ff;

endmodule

//--- rtl/banked_reg_result.sv
`timescale 1ns/1ps

module banked_reg_result
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  wb_pkg::wb_write_t   i_write,
        input  wb_pkg::reg_idx_t    i_rd_index_0,
        input  wb_pkg::reg_idx_t    i_rd_index_1,
        output wb_pkg::word_t       o_rd_data_0,
        output wb_pkg::word_t       o_rd_data_1
);

        import wb_pkg::*;

        word_t regs_ff [PHY_REGS];

        // Real storage only; RAZ slot and unused codes read as zero.
        function automatic logic is_live(input reg_idx_t idx);
                return (idx != PHY_RAZ_REGISTER) && (int'(idx) < PHY_REGS);
        endfunction

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < PHY_REGS; i++)
                        begin
                                regs_ff[i] <= '0;
                        end
                end
                else if (i_write.wen)
                begin
                        // Port 2 first so port 1 wins a collision.
                        if (is_live(i_write.wa2))
                                regs_ff[i_write.wa2] <= i_write.wdata2;
                        if (is_live(i_write.wa1))
                                regs_ff[i_write.wa1] <= i_write.wdata1;
                end
        end

        // Combinational reads.
        assign o_rd_data_0 = is_live(i_rd_index_0) ? regs_ff[i_rd_index_0] : '0;
        assign o_rd_data_1 = is_live(i_rd_index_1) ? regs_ff[i_rd_index_1] : '0;

endmodule

//--- rtl/wb_core_top.sv
`timescale 1ns/1ps

module wb_core_top
(
        input  logic                i_clk,
        input  logic                i_reset,
        // Order from bit 5 down is dabt, fiq, irq, pabt, swi, und.
        input  logic [5:0]          i_exc,
        input  logic                i_data_stall,
        input  logic                i_clear_from_alu,
        input  wb_pkg::word_t       i_pc_from_alu,
        input  logic                i_stall_from_issue,
        input  logic                i_clear_from_decode,
        input  wb_pkg::word_t       i_pc_from_decode,
        input  logic                i_stall_from_decode,
        input  logic                i_code_stall,
        input  wb_pkg::commit_t     i_commit,
        input  wb_pkg::word_t       i_pc_buf,
        input  wb_pkg::reg_idx_t    i_rd_index_0,
        input  wb_pkg::reg_idx_t    i_rd_index_1,
        output wb_pkg::word_t       o_pc,
        output wb_pkg::word_t       o_cpsr,
        output wb_pkg::word_t       o_rd_data_0,
        output wb_pkg::word_t       o_rd_data_1,
        output logic                o_clear_from_writeback,
        output logic                o_fiq_ack,
        output logic                o_irq_ack
);

        import wb_pkg::*;

        wb_event_t wb_event;
        wb_write_t wb_write;

        wb_event_decode u_decode
        (
                .i_exc               (i_exc),
                .i_data_stall        (i_data_stall),
                .i_clear_from_alu    (i_clear_from_alu),
                .i_pc_from_alu       (i_pc_from_alu),
                .i_stall_from_issue  (i_stall_from_issue),
                .i_clear_from_decode (i_clear_from_decode),
                .i_pc_from_decode    (i_pc_from_decode),
                .i_stall_from_decode (i_stall_from_decode),
                .i_code_stall        (i_code_stall),
                .i_commit            (i_commit),
                .o_event             (wb_event)
        );

        wb_state_execute u_execute
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_event                (wb_event),
                .i_commit               (i_commit),
                .i_pc_buf               (i_pc_buf),
                .o_pc                   (o_pc),
                .o_cpsr                 (o_cpsr),
                .o_write                (wb_write),
                .o_clear_from_writeback (o_clear_from_writeback),
                .o_fiq_ack              (o_fiq_ack),
                .o_irq_ack              (o_irq_ack)
        );

        banked_reg_result u_result
        (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_write      (wb_write),
                .i_rd_index_0 (i_rd_index_0),
                .i_rd_index_1 (i_rd_index_1),
                .o_rd_data_0  (o_rd_data_0),
                .o_rd_data_1  (o_rd_data_1)
        );

endmodule

//--- verification/wb_checker.sv
`timescale 1ns/1ps

module wb_checker
(
        input  logic                i_clk,
        input  logic                i_active,
        input  wb_pkg::word_t       i_exp_pc,
        input  wb_pkg::word_t       i_exp_cpsr,
        input  wb_pkg::word_t       i_exp_rd_0,
        input  wb_pkg::word_t       i_exp_rd_1,
        // Clear, FIQ ack, IRQ ack.
        input  logic [2:0]          i_exp_strobes,
        input  wb_pkg::word_t       i_pc,
        input  wb_pkg::word_t       i_cpsr,
        input  wb_pkg::word_t       i_rd_data_0,
        input  wb_pkg::word_t       i_rd_data_1,
        input  logic                i_clear,
        input  logic                i_fiq_ack,
        input  logic                i_irq_ack,
        output int                  o_errors,
        output int                  o_rows_done
);

        import wb_pkg::*;

        int    errors = 0;
        int    rows_done = 0;
        int    row = 0;

        // State expected one cycle after its row.
        logic  pend = 1'b0;
        int    pend_row;
        word_t pend_pc;
        word_t pend_cpsr;

        task automatic compare(input string what, input int idx, input word_t got,
                               input word_t exp);
                if (got !== exp)
                begin
                        $display("ERROR: time %0d ns, row %0d %s is %h, expected %h",
                                 $time, idx, what, got, exp);
                        errors++;
                end
        endtask

        // Sampled mid-cycle, away from the driving edge.
        always @(negedge i_clk)
        begin
                if (pend)
                begin
                        compare("pc", pend_row, i_pc, pend_pc);
                        compare("cpsr", pend_row, i_cpsr, pend_cpsr);
                        rows_done++;
                end
                pend = i_active;
                if (i_active)
                begin
                        compare("read data 0", row, i_rd_data_0, i_exp_rd_0);
                        compare("read data 1", row, i_rd_data_1, i_exp_rd_1);
                        compare("clear/fiq ack/irq ack", row,
                                32'({i_clear, i_fiq_ack, i_irq_ack}), 32'(i_exp_strobes));
                        pend_row = row;
                        pend_pc = i_exp_pc;
                        pend_cpsr = i_exp_cpsr;
                        row++;
                end
        end

        assign o_errors    = errors;
        assign o_rows_done = rows_done;

endmodule

//--- verification/tb_wb_core.sv
`timescale 1ns/1ps

module tb_wb_core;

        import wb_pkg::*;

        localparam int       TIMEOUT = 40;
        localparam reg_idx_t RAZ     = PHY_RAZ_REGISTER;

        typedef struct packed {
                logic [5:0] exc;
                // Data stall, ALU clear, issue stall, decode clear, decode stall, code stall.
                logic [5:0] ctl;
                word_t      pc_in;
                commit_t    cm;
                word_t      pc_buf;
                reg_idx_t   rd_0;
                reg_idx_t   rd_1;
                word_t      pc;
                word_t      cpsr;
                word_t      d_0;
                word_t      d_1;
                // Clear, FIQ ack, IRQ ack.
                logic [2:0] strobes;
        } row_t;

        logic       i_clk;
        logic       i_reset;
        logic [5:0] i_exc;
        logic       i_data_stall, i_clear_from_alu, i_stall_from_issue;
        logic       i_clear_from_decode, i_stall_from_decode, i_code_stall;
        word_t      i_pc_from_alu, i_pc_from_decode, i_pc_buf;
        commit_t    i_commit;
        reg_idx_t   i_rd_index_0, i_rd_index_1;
        word_t      o_pc, o_cpsr, o_rd_data_0, o_rd_data_1;
        logic       o_clear_from_writeback, o_fiq_ack, o_irq_ack;

        // Expected values of the row now on the inputs.
        logic       row_active;
        word_t      exp_pc, exp_cpsr, exp_rd_0, exp_rd_1;
        logic [2:0] exp_strobes;

        row_t       rows[$];
        word_t      rnd[4];
        integer     seed;
        int         errors;
        int         rows_done;
        int         timeouts;

        wb_core_top uut (.*);

        wb_checker u_checker
        (
                .i_clk         (i_clk),
                .i_active      (row_active),
                .i_exp_pc      (exp_pc),
                .i_exp_cpsr    (exp_cpsr),
                .i_exp_rd_0    (exp_rd_0),
                .i_exp_rd_1    (exp_rd_1),
                .i_exp_strobes (exp_strobes),
                .i_pc          (o_pc),
                .i_cpsr        (o_cpsr),
                .i_rd_data_0   (o_rd_data_0),
                .i_rd_data_1   (o_rd_data_1),
                .i_clear       (o_clear_from_writeback),
                .i_fiq_ack     (o_fiq_ack),
                .i_irq_ack     (o_irq_ack),
                .o_errors      (errors),
                .o_rows_done   (rows_done)
        );

        function automatic commit_t make_commit(input logic ld, input reg_idx_t a0,
                                                input reg_idx_t a1, input word_t d0,
                                                input word_t d1, input word_t fl);
                return '{valid: 1'b1, mem_load: ld, wr_index: a0, wr_index_1: a1,
                         wr_data: d0, wr_data_1: d1, flags: fl};
        endfunction

        task automatic add_row(input logic [5:0] exc, input logic [5:0] ctl,
                               input word_t pc_in, input commit_t cm, input word_t pc_buf,
                               input reg_idx_t rd_0, input reg_idx_t rd_1, input word_t pc,
                               input word_t cpsr, input word_t d_0, input word_t d_1,
                               input logic [2:0] strobes);
                row_t r;

                r = '{exc, ctl, pc_in, cm, pc_buf, rd_0, rd_1, pc, cpsr, d_0, d_1, strobes};
                rows.push_back(r);
        endtask

        task automatic load_table();
                // Advance, then stall and clear priority.
                add_row('0, '0, '0, '0, '0, RAZ, RAZ, 32'h4, 32'hD3, '0, '0, 3'b000);
                add_row('0, '0, '0, '0, '0, RAZ, RAZ, 32'h8, 32'hD3, '0, '0, 3'b000);
                add_row('0, 6'b110000, 32'h100, '0, '0, RAZ, RAZ, 32'h8, 32'hD3, '0, '0, 3'b000);
                add_row('0, 6'b010000, 32'h203, '0, '0, RAZ, RAZ, 32'h202, 32'hD3, '0, '0, 3'b000);
                add_row('0, 6'b001100, 32'h300, '0, '0, RAZ, RAZ, 32'h202, 32'hD3, '0, '0, 3'b000);
                add_row('0, 6'b000100, 32'h300, '0, '0, RAZ, RAZ, 32'h300, 32'hD3, '0, '0, 3'b000);
                add_row('0, 6'b000010, '0, '0, '0, RAZ, RAZ, 32'h300, 32'hD3, '0, '0, 3'b000);
                add_row('0, 6'b000001, '0, '0, '0, RAZ, RAZ, 32'h300, 32'hD3, '0, '0, 3'b000);
                add_row('0, '0, '0, '0, '0, RAZ, RAZ, 32'h304, 32'hD3, '0, '0, 3'b000);
                // IRQ beats SWI and UND, and overrides the data stall.
                add_row(6'b001011, 6'b100000, '0, '0, 32'h304, RAZ, RAZ,
                        32'h18, 32'hD2, '0, '0, 3'b101);
                add_row('0, '0, '0, '0, '0, PHY_IRQ_R14, PHY_IRQ_SPSR,
                        32'h1C, 32'hD2, 32'h304, 32'hD3, 3'b000);
                add_row(6'b010100, '0, '0, '0, 32'h1C, RAZ, RAZ, 32'h1C, 32'hD1, '0, '0, 3'b110);
                add_row('0, '0, '0, '0, '0, PHY_FIQ_R14, PHY_FIQ_SPSR,
                        32'h20, 32'hD1, 32'h1C, 32'hD2, 3'b000);
                add_row(6'b110000, '0, '0, '0, 32'h20, RAZ, RAZ, 32'h10, 32'hD7, '0, '0, 3'b100);
                add_row('0, '0, '0, '0, '0, PHY_ABT_R14, PHY_ABT_SPSR,
                        32'h14, 32'hD7, 32'h20, 32'hD1, 3'b000);
                // Register commits, RAZ slot and a port collision.
                add_row('0, 6'b100000, '0, make_commit(1'b1, 6'd3, 6'd5, rnd[0], rnd[1],
                        32'h2000_0010), '0, 6'd3, 6'd5, 32'h14, 32'h2000_0010, '0, '0, 3'b000);
                add_row('0, '0, '0, make_commit(1'b0, RAZ, 6'd5, rnd[2], rnd[3], 32'h4000_0010),
                        '0, 6'd3, 6'd5, 32'h14, 32'h4000_0010, rnd[0], rnd[1], 3'b000);
                add_row('0, '0, '0, make_commit(1'b1, 6'd7, 6'd7, rnd[2], rnd[3], 32'h8000_0010),
                        '0, RAZ, 6'd5, 32'h14, 32'h8000_0010, '0, rnd[1], 3'b000);
                // UND from a mode with F clear leaves F alone.
                add_row(6'b000001, '0, '0, '0, 32'h14, 6'd7, 6'd3,
                        32'h4, 32'h8000_009B, rnd[2], rnd[0], 3'b100);
                // PC and status commits through the four cpsr sources.
                add_row('0, '0, '0, make_commit(1'b0, ARCH_PC, RAZ, 32'h401, 32'h6000_0033,
                        32'hF000_0010), '0, PHY_UND_R14, PHY_UND_SPSR,
                        32'h400, 32'h6000_0013, 32'h14, 32'h8000_0010, 3'b100);
                add_row('0, '0, '0, make_commit(1'b0, PHY_CPSR, RAZ, 32'h1000_00D3, '0, '0),
                        '0, RAZ, RAZ, 32'h400, 32'h1000_00D3, '0, '0, 3'b000);
                add_row('0, '0, '0, make_commit(1'b1, 6'd2, PHY_CPSR, rnd[0], 32'h2000_0032, '0),
                        '0, RAZ, RAZ, 32'h400, 32'h2000_0012, '0, '0, 3'b000);
                add_row('0, '0, '0, make_commit(1'b1, 6'd4, ARCH_PC, rnd[1], 32'h803, 32'h10),
                        '0, RAZ, RAZ, 32'h802, 32'h10, '0, '0, 3'b100);
                add_row('0, '0, '0, '0, '0, 6'd2, 6'd4, 32'h806, 32'h10, rnd[0], rnd[1], 3'b000);
                add_row('0, '0, '0, '0, '0, PHY_CPSR, 6'd5,
                        32'h80A, 32'h10, 32'h2000_0032, rnd[1], 3'b000);
        endtask

        initial
        begin
                i_clk = 1'b0;
                forever #2 i_clk = ~i_clk;
        end

        initial
        begin
                row_t r;
                int   waited;

                seed = 32'h18f5_c3d0;
                timeouts = 0;
                i_reset = 1'b1;
                i_exc = '0;
                // Idle cycles hold the PC.
                {i_data_stall, i_clear_from_alu, i_stall_from_issue} = 3'b100;
                {i_clear_from_decode, i_stall_from_decode, i_code_stall} = 3'b000;
                i_pc_from_alu = '0;
                i_pc_from_decode = '0;
                i_pc_buf = '0;
                i_commit = '0;
                i_rd_index_0 = RAZ;
                i_rd_index_1 = RAZ;
                row_active = 1'b0;
                {exp_pc, exp_cpsr, exp_rd_0, exp_rd_1, exp_strobes} = '0;
                for (int i = 0; i < 4; i++)
                begin
                        rnd[i] = $random(seed);
                end
                load_table();

                repeat (2) @(posedge i_clk);
                i_reset <= 1'b0;
                waited = 0;
                while (!(o_pc === 32'h0 && o_cpsr === 32'hD3) && waited < TIMEOUT)
                begin
                        @(negedge i_clk);
                        waited++;
                end
                if (waited == TIMEOUT)
                begin
                        $display("Timeout waiting for pc 0 and SVC status after reset.");
                        timeouts++;
                end

                foreach (rows[i])
                begin
                        @(posedge i_clk);
                        r = rows[i];
                        i_exc <= r.exc;
                        {i_data_stall, i_clear_from_alu, i_stall_from_issue,
                         i_clear_from_decode, i_stall_from_decode, i_code_stall} <= r.ctl;
                        // Only the clearing source carries the row's address.
                        i_pc_from_alu <= r.ctl[4] ? r.pc_in : ~r.pc_in;
                        i_pc_from_decode <= r.ctl[2] ? r.pc_in : ~r.pc_in;
                        i_commit <= r.cm;
                        i_pc_buf <= r.pc_buf;
                        i_rd_index_0 <= r.rd_0;
                        i_rd_index_1 <= r.rd_1;
                        {exp_pc, exp_cpsr, exp_rd_0, exp_rd_1} <= {r.pc, r.cpsr, r.d_0, r.d_1};
                        exp_strobes <= r.strobes;
                        row_active <= 1'b1;
                end
                @(posedge i_clk);
                i_exc <= '0;
                i_commit <= '0;
                {i_data_stall, i_clear_from_alu, i_stall_from_issue,
                 i_clear_from_decode, i_stall_from_decode, i_code_stall} <= 6'b100000;
                row_active <= 1'b0;

                waited = 0;
                while (rows_done < rows.size() && waited < TIMEOUT)
                begin
                        @(negedge i_clk);
                        waited++;
                end
                if (rows_done < rows.size())
                begin
                        $display("Timeout waiting for the checker to finish all rows.");
                        timeouts++;
                end

                $display("Checks done: %0d of %0d rows, %0d value errors, %0d timeouts",
                         rows_done, rows.size(), errors, timeouts);
                if (errors == 0 && timeouts == 0)
                        $display("STATUS: PASS");
                else
                        $display("STATUS: FAIL");
                $finish;
        end

endmodule

//--- flist.f
rtl/wb_pkg.sv
rtl/wb_event_decode.sv
rtl/wb_state_execute.sv
rtl/banked_reg_result.sv
rtl/wb_core_top.sv
verification/wb_checker.sv
verification/tb_wb_core.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_wb_core
RTL_TOP   ?= wb_core_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
